//--- hw/rvCorePkg.sv
// RV32I subset only; opcode bits 1..0 are assumed to be 2'b11 and checked in decode
package rvCorePkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // ==============================
    // major opcodes, instr[6:2]
    // ==============================
    localparam logic [4:0] opOp     = 5'b01100;
    localparam logic [4:0] opOpImm  = 5'b00100;
    localparam logic [4:0] opBranch = 5'b11000;
    localparam logic [4:0] opJal    = 5'b11011;

    // alu codes are {instr[30], funct3}
    localparam logic [3:0] aluAdd = 4'b0000;
    localparam logic [3:0] aluSub = 4'b1000;
    localparam logic [3:0] aluSlt = 4'b0010;
    localparam logic [3:0] aluXor = 4'b0100;
    localparam logic [3:0] aluOr  = 4'b0110;
    localparam logic [3:0] aluAnd = 4'b0111;
    localparam logic [3:0] aluSll = 4'b0001;
    localparam logic [3:0] aluSrl = 4'b0101;
    localparam logic [3:0] aluSra = 4'b1101;

    // ==============================
    // instruction formats
    // ==============================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    // branch offset is scattered over both ends of the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        bFmtT bFmt;
        jFmtT jFmt;
    } instrU;

endpackage

//--- hw/stageIf.sv
// plain signal bundles, no clocking; the producer side owns every register behind them
`timescale 1ns/100ps

// decode/execute register contents
interface idExIf import rvCorePkg::*; ();
    logic                valid;
    logic [xlen-1:0]     pc;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     rs1Val;
    logic [xlen-1:0]     rs2Val;
    logic [xlen-1:0]     imm;
    logic [3:0]          aluOp;
    logic                useImm;
    logic                isBranch;
    logic                branchNe;
    logic                isJal;
    logic                regWrite;

    modport producer (output valid, pc, rs1, rs2, rd, rs1Val, rs2Val, imm, aluOp, useImm,
                      isBranch, branchNe, isJal, regWrite);
    modport consumer (input valid, pc, rs1, rs2, rd, rs1Val, rs2Val, imm, aluOp, useImm,
                      isBranch, branchNe, isJal, regWrite);
endinterface

// execute stage <-> pipeline control
interface hazardIf import rvCorePkg::*; ();
    logic [regAddrW-1:0] rs1Ex;
    logic [regAddrW-1:0] rs2Ex;
    logic                wbRegWrite;
    logic [regAddrW-1:0] wbRd;
    logic                redirect;
    logic                advance;
    logic                flush;
    logic                fwdA;
    logic                fwdB;

    modport stage (output rs1Ex, rs2Ex, wbRegWrite, wbRd, redirect, input fwdA, fwdB);
    modport ctrl  (input rs1Ex, rs2Ex, wbRegWrite, wbRd, redirect,
                   output advance, flush, fwdA, fwdB);
endinterface

//--- hw/pipeControl.sv
// one global freeze for the whole pipe; only the writeback register is a forwarding source
`timescale 1ns/100ps

module pipeControl import rvCorePkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   imemStall,
    hazardIf.ctrl  hz,
    output logic   advance,
    output logic   flush
);

    // pipe holds for the first cycle after reset release
    logic runQ;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            runQ <= 1'b0;
        end else begin
            runQ <= 1'b1;
        end
    end

    // ==============================
    // freeze and squash
    // ==============================
    assign hz.advance = runQ & ~imemStall;
    // a redirect seen while frozen waits for the next advancing edge
    assign hz.flush   = hz.redirect & hz.advance;

    assign advance = hz.advance;
    assign flush   = hz.flush;

    // x0 never forwards
    assign hz.fwdA = hz.wbRegWrite && (hz.wbRd != '0) && (hz.wbRd == hz.rs1Ex);
    assign hz.fwdB = hz.wbRegWrite && (hz.wbRd != '0) && (hz.wbRd == hz.rs2Ex);

endmodule

//--- hw/fetchUnit.sv
// instruction port reads one cycle after the address; the word is taken without byte swap
`timescale 1ns/100ps

module fetchUnit import rvCorePkg::*; #(
    parameter logic [xlen-1:0] resetPc = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,
    input  logic            flush,
    input  logic [xlen-1:0] redirectPc,
    output logic [xlen-3:0] imemAddr,
    input  logic [xlen-1:0] imemData,
    output instrU           ifInstr,
    output logic [xlen-1:0] ifPc,
    output logic            ifValid
);

    logic [xlen-1:0] pc;
    // address and validity of the word now on imemData
    logic [xlen-1:0] reqPc;
    logic            reqValid;

    assign imemAddr = pc[xlen-1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= resetPc;
            reqValid <= 1'b0;
            ifValid  <= 1'b0;
        end else if (advance) begin
            pc       <= flush ? redirectPc : pc + 4;
            // word returning next cycle was asked for on the wrong path
            reqValid <= ~flush;
            ifValid  <= reqValid & ~flush;
        end
    end

    // payload only, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (advance) begin
            reqPc   <= pc;
            ifPc    <= reqPc;
            ifInstr <= instrU'(imemData);
        end
    end

endmodule

//--- hw/decodeUnit.sv
// unsupported opcodes and funct codes (loads, stores, jalr, sltu...) decode to bubbles
`timescale 1ns/100ps

module decodeUnit import rvCorePkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    input  logic                flush,
    input  instrU               ifInstr,
    input  logic [xlen-1:0]     ifPc,
    input  logic                ifValid,
    output logic [regAddrW-1:0] rs1Addr,
    output logic [regAddrW-1:0] rs2Addr,
    input  logic [xlen-1:0]     rs1Data,
    input  logic [xlen-1:0]     rs2Data,
    idExIf.producer             idEx
);

    logic [4:0]      opc;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;
    logic [3:0]      dAluOp;
    logic [xlen-1:0] dImm;
    logic            dUseImm;
    logic            dBranch;
    logic            dJal;
    logic            dWrite;
    logic            dLegal;
    logic            keep;

    function automatic logic isAluCode(input logic [3:0] code);
        return code inside {aluAdd, aluSub, aluSlt, aluXor, aluOr, aluAnd,
                            aluSll, aluSrl, aluSra};
    endfunction

    assign opc     = ifInstr.rFmt.opcode[6:2];
    assign rs1Addr = ifInstr.rFmt.rs1;
    assign rs2Addr = ifInstr.rFmt.rs2;

    // ==============================
    // immediates
    // ==============================
    assign immI = {{20{ifInstr.iFmt.imm12[11]}}, ifInstr.iFmt.imm12};
    assign immB = {{20{ifInstr.bFmt.imm12}}, ifInstr.bFmt.imm11, ifInstr.bFmt.imm10to5,
                   ifInstr.bFmt.imm4to1, 1'b0};
    assign immJ = {{12{ifInstr.jFmt.imm20}}, ifInstr.jFmt.imm19to12, ifInstr.jFmt.imm11,
                   ifInstr.jFmt.imm10to1, 1'b0};

    always_comb begin
        dAluOp  = {ifInstr.rFmt.funct7[5], ifInstr.rFmt.funct3};
        dImm    = immI;
        dUseImm = 1'b0;
        dBranch = 1'b0;
        dJal    = 1'b0;
        dWrite  = 1'b0;
        dLegal  = 1'b0;
        case (opc)
            opOp: begin
                dWrite = 1'b1;
                dLegal = isAluCode(dAluOp);
            end
            opOpImm: begin
                // bit 30 only selects sra among the immediate forms
                if (ifInstr.iFmt.funct3 != 3'b101) begin
                    dAluOp = {1'b0, ifInstr.iFmt.funct3};
                end
                dUseImm = 1'b1;
                dWrite  = 1'b1;
                dLegal  = isAluCode(dAluOp);
            end
            opBranch: begin
                dImm    = immB;
                dBranch = 1'b1;
                // beq and bne only
                dLegal  = (ifInstr.bFmt.funct3[2:1] == 2'b00);
            end
            opJal: begin
                dImm   = immJ;
                dJal   = 1'b1;
                dWrite = 1'b1;
                dLegal = 1'b1;
            end
            default: dLegal = 1'b0;
        endcase
        if (ifInstr.rFmt.opcode[1:0] != 2'b11) begin
            dLegal = 1'b0;
        end
    end

    assign keep = ifValid & dLegal & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx.valid    <= 1'b0;
            idEx.isBranch <= 1'b0;
            idEx.isJal    <= 1'b0;
            idEx.regWrite <= 1'b0;
        end else if (advance) begin
            idEx.valid    <= keep;
            idEx.isBranch <= dBranch;
            idEx.isJal    <= dJal;
            idEx.regWrite <= dWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            idEx.pc       <= ifPc;
            idEx.rs1      <= ifInstr.rFmt.rs1;
            idEx.rs2      <= ifInstr.rFmt.rs2;
            idEx.rd       <= ifInstr.rFmt.rd;
            idEx.rs1Val   <= rs1Data;
            idEx.rs2Val   <= rs2Data;
            idEx.imm      <= dImm;
            idEx.aluOp    <= dAluOp;
            idEx.useImm   <= dUseImm;
            idEx.branchNe <= ifInstr.bFmt.funct3[0];
        end
    end

endmodule

//--- hw/regFile.sv
// two read ports, one write port; reset clears all registers so programs start from zero
`timescale 1ns/100ps

module regFile import rvCorePkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  logic [regAddrW-1:0] wAddr,
    input  logic [xlen-1:0]     wData,
    input  logic [regAddrW-1:0] rAddrA,
    input  logic [regAddrW-1:0] rAddrB,
    output logic [xlen-1:0]     rDataA,
    output logic [xlen-1:0]     rDataB
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    // same-cycle write is seen by the reader
    function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
        logic [xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we && addr == wAddr) begin
            value = wData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb rDataA = readPort(rAddrA);
    always_comb rDataB = readPort(rAddrB);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

endmodule

//--- hw/executeUnit.sv
// branches and jal resolve here; wbValid is held low while the pipe is frozen
`timescale 1ns/100ps

module executeUnit import rvCorePkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                advance,
    idExIf.consumer             idEx,
    hazardIf.stage              hz,
    output logic [xlen-1:0]     redirectPc,
    output logic                wbValid,
    output logic [regAddrW-1:0] wbRd,
    output logic [xlen-1:0]     wbData
);

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluOut;
    logic [xlen-1:0] result;
    logic [4:0]      shamt;
    logic            taken;
    // writeback register valid, before the freeze gate
    logic            wbValidQ;

    // ==============================
    // operands
    // ==============================
    assign hz.rs1Ex = idEx.rs1;
    assign hz.rs2Ex = idEx.rs2;

    assign opA   = hz.fwdA ? wbData : idEx.rs1Val;
    assign opB   = hz.fwdB ? wbData : idEx.rs2Val;
    assign aluB  = idEx.useImm ? idEx.imm : opB;
    assign shamt = aluB[4:0];

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluOut = opA + aluB;
            aluSub:  aluOut = opA - aluB;
            aluSlt:  aluOut = {{(xlen-1){1'b0}}, $signed(opA) < $signed(aluB)};
            aluXor:  aluOut = opA ^ aluB;
            aluOr:   aluOut = opA | aluB;
            aluAnd:  aluOut = opA & aluB;
            aluSll:  aluOut = opA << shamt;
            aluSrl:  aluOut = opA >> shamt;
            aluSra:  aluOut = $signed(opA) >>> shamt;
            default: aluOut = '0;
        endcase
    end

    // ==============================
    // branch and jump
    // ==============================
    assign taken       = idEx.isBranch & (idEx.branchNe ? (opA != opB) : (opA == opB));
    assign hz.redirect = idEx.valid & (idEx.isJal | taken);
    assign redirectPc  = idEx.pc + idEx.imm;

    // link address for jal
    assign result = idEx.isJal ? idEx.pc + 4 : aluOut;

    // ==============================
    // writeback register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbValidQ <= 1'b0;
        end else if (advance) begin
            wbValidQ <= idEx.valid & idEx.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wbRd   <= idEx.rd;
            wbData <= result;
        end
    end

    // retires once, on the advancing cycle, so no duplicate under stall
    assign wbValid = wbValidQ & advance;

    assign hz.wbRegWrite = wbValidQ;
    assign hz.wbRd       = wbRd;

endmodule

//--- hw/rvCore.sv
// no loads or stores; results are visible only on the wb trace port, resetPc must be word aligned
`timescale 1ns/100ps

module rvCore import rvCorePkg::*; #(
    parameter logic [xlen-1:0] resetPc = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    output logic [xlen-3:0]     imemAddr,
    input  logic [xlen-1:0]     imemData,
    input  logic                imemStall,
    output logic                wbValid,
    output logic [regAddrW-1:0] wbRd,
    output logic [xlen-1:0]     wbData
);

    logic                advance;
    logic                flush;
    logic [xlen-1:0]     redirectPc;
    instrU               ifInstr;
    logic [xlen-1:0]     ifPc;
    logic                ifValid;
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;

    idExIf   idEx ();
    hazardIf hz ();

    pipeControl uCtrl (.clk, .rst_n, .imemStall, .hz(hz.ctrl), .advance, .flush);

    fetchUnit #(.resetPc(resetPc)) uFetch (
        .clk, .rst_n, .advance, .flush, .redirectPc,
        .imemAddr, .imemData, .ifInstr, .ifPc, .ifValid
    );

    decodeUnit uDecode (
        .clk, .rst_n, .advance, .flush, .ifInstr, .ifPc, .ifValid,
        .rs1Addr, .rs2Addr, .rs1Data, .rs2Data, .idEx(idEx.producer)
    );

    // written from the writeback register
    regFile uRegs (
        .clk, .rst_n, .we(wbValid), .wAddr(wbRd), .wData(wbData),
        .rAddrA(rs1Addr), .rAddrB(rs2Addr), .rDataA(rs1Data), .rDataB(rs2Data)
    );

    executeUnit uExec (
        .clk, .rst_n, .advance, .idEx(idEx.consumer), .hz(hz.stage),
        .redirectPc, .wbValid, .wbRd, .wbData
    );

endmodule

//--- dv/rvRefModel.svh
// included inside tbRvCore; needs prog, expRd, expData and resetPc declared before it
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// jal x0, 0
localparam logic [31:0] selfJump = 32'h0000_006f;

// ==============================
// instruction encoders
// ==============================
function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                     input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
endfunction

function automatic logic [31:0] encB(input int off, input int rs2, input int rs1,
                                     input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] encJ(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
endfunction

// anything outside the program reads as a self-jump
function automatic logic [31:0] fetchWord(input logic [29:0] wordAddr);
    logic [31:0] idx;
    idx = {2'b00, wordAddr} - {2'b00, resetPc[31:2]};
    if (idx < 32'(prog.size())) begin
        return prog[idx];
    end
    return selfJump;
endfunction

// RV32I integer semantics by funct3, alt is bit 30 where it applies
function automatic logic [31:0] aluRef(input logic alt, input logic [2:0] f3,
                                       input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'd0, $signed(a) < $signed(b)};
        3'd4: r = a ^ b;
        3'd6: r = a | b;
        3'd7: r = a & b;
        default: r = '0;
    endcase
    if (f3 == 3'd5) begin
        if (alt) begin
            r = $signed(a) >>> b[4:0];
        end else begin
            r = a >> b[4:0];
        end
    end
    return r;
endfunction

// ==============================
// architectural reference run
// ==============================
function automatic void buildTrace();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic        writes;
    bit          stop;
    int          steps;
    int          i;
    for (i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc    = resetPc;
    stop  = 1'b0;
    steps = 0;
    while (!stop && steps < 1000) begin
        ins    = fetchWord(pc[31:2]);
        a      = x[ins[19:15]];
        b      = x[ins[24:20]];
        res    = '0;
        writes = 1'b0;
        nextPc = pc + 4;
        case (ins[6:0])
            7'h33: begin
                res    = aluRef(ins[30], ins[14:12], a, b);
                writes = 1'b1;
            end
            7'h13: begin
                // bit 30 of an immediate only matters for the right shifts
                res    = aluRef(ins[14:12] == 3'd5 && ins[30], ins[14:12], a,
                                {{20{ins[31]}}, ins[31:20]});
                writes = 1'b1;
            end
            7'h63: begin
                // beq when funct3 bit 0 is clear, bne when set
                if ((a == b) != ins[12]) begin
                    nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'h6f: begin
                res    = pc + 4;
                writes = 1'b1;
                nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                stop   = (nextPc == pc);
            end
            default: stop = 1'b1;
        endcase
        if (writes) begin
            expRd.push_back(ins[11:7]);
            expData.push_back(res);
            if (ins[11:7] != 5'd0) begin
                x[ins[11:7]] = res;
            end
        end
        pc = nextPc;
        steps++;
    end
endfunction

`endif

//--- dv/tbRvCore.sv
// resetPc fixed at 0x100; immediates and stall pattern come from one seed, run ends at self-jump
`timescale 1ns/100ps

module tbRvCore;

    localparam logic [31:0] resetPc = 32'h0000_0100;

    logic        clk;
    logic        rst_n;
    logic [29:0] imemAddr;
    logic [31:0] imemData;
    logic        imemStall;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;

    logic [31:0] prog [$];
    logic [4:0]  expRd [$];
    logic [31:0] expData [$];
    integer      seed = 65989;
    int          errCount = 0;
    int          expIdx = 0;
    int          cycleCount = 0;
    int          cycleLimit = 100;
    bit          stallOn = 1'b0;
    bit          done = 1'b0;
    bit          timedOut = 1'b0;

    `include "rvRefModel.svh"

    rvCore #(.resetPc(resetPc)) dut (
        .clk, .rst_n, .imemAddr, .imemData, .imemStall, .wbValid, .wbRd, .wbData
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
            errCount++;
        end
    endtask

    task automatic checkReset();
        checkVal("wbValid", 32'd0, {31'd0, wbValid});
        checkVal("imemAddr", resetPc >> 2, {2'b00, imemAddr});
    endtask

    task automatic loadProgram();
        int r1;
        int r2;
        int r3;
        int r4;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        r4 = $random(seed);
        prog.push_back(encI(r1, 0, 0, 1));
        prog.push_back(encI(-7, 0, 0, 2));
        // x3 used next, then second-next through the regfile bypass
        prog.push_back(encR(0, 2, 1, 0, 3));
        prog.push_back(encR(32, 3, 1, 0, 4));
        prog.push_back(encR(0, 1, 3, 2, 5));
        // negative against positive
        prog.push_back(encR(0, 4, 2, 2, 6));
        prog.push_back(encI(r2, 2, 2, 7));
        prog.push_back(encR(0, 2, 1, 4, 8));
        prog.push_back(encR(0, 3, 8, 6, 9));
        prog.push_back(encR(0, 8, 9, 7, 10));
        prog.push_back(encI(r3, 10, 4, 11));
        prog.push_back(encI(r4, 11, 7, 12));
        prog.push_back(encI(12'h0f0, 12, 6, 13));
        // shifts of a negative value, logical vs arithmetic
        prog.push_back(encI(4, 1, 1, 14));
        prog.push_back(encI(3, 2, 5, 15));
        prog.push_back(encI(32'h403, 2, 5, 16));
        prog.push_back(encI(5, 0, 0, 17));
        prog.push_back(encR(0, 17, 2, 5, 18));
        prog.push_back(encR(32, 17, 2, 5, 19));
        prog.push_back(encR(0, 17, 1, 1, 20));
        // x0 written, then read right away
        prog.push_back(encI(99, 1, 0, 0));
        prog.push_back(encR(0, 1, 0, 0, 21));
        prog.push_back(encB(12, 3, 3, 0));
        prog.push_back(encI(1, 0, 0, 22));
        prog.push_back(encI(2, 0, 0, 23));
        prog.push_back(encB(8, 3, 3, 1));
        prog.push_back(encB(8, 17, 2, 0));
        prog.push_back(encB(12, 17, 2, 1));
        prog.push_back(encI(3, 0, 0, 24));
        prog.push_back(encI(4, 0, 0, 25));
        prog.push_back(encJ(12, 26));
        prog.push_back(encI(5, 0, 0, 27));
        prog.push_back(encI(6, 0, 0, 28));
        prog.push_back(encR(0, 26, 26, 0, 29));
        prog.push_back(encI(-1, 29, 0, 30));
    endtask

    // ==============================
    // instruction port model
    // ==============================
    always @(posedge clk) begin
        if (!imemStall) begin
            imemData <= fetchWord(imemAddr);
        end
        if (stallOn) begin
            imemStall <= ($random(seed) & 3) == 0;
        end
    end

    // trace compare, in order
    always @(posedge clk) begin
        if (rst_n && wbValid && !done && !timedOut) begin
            checkVal("wbRd", {27'd0, expRd[expIdx]}, {27'd0, wbRd});
            checkVal("wbData", expData[expIdx], wbData);
            expIdx++;
            done = (expIdx == expRd.size());
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (!done && !timedOut && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, only %0d of %0d register writes retired",
                     cycleCount, expIdx, expRd.size());
            errCount++;
            timedOut = 1'b1;
        end
    end

    // ==============================
    // main sequence
    // ==============================
    initial begin
        rst_n     = 1'b0;
        imemStall = 1'b0;
        imemData  = '0;
        loadProgram();
        buildTrace();
        cycleLimit = 40 * expRd.size() + 100;
        // first edge applies the reset, later reset edges see its state
        @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            checkReset();
        end
        rst_n <= 1'b1;
        @(posedge clk);
        checkReset();
        stallOn <= 1'b1;
        wait (done || timedOut);
        $display("errors: %0d, retired %0d of %0d expected writes",
                 errCount, expIdx, expRd.size());
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
hw/rvCorePkg.sv
hw/stageIf.sv
hw/pipeControl.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/regFile.sv
hw/executeUnit.sv
hw/rvCore.sv
dv/tbRvCore.sv

//--- Makefile
# Verilator build and run for the rvCore testbench
VERILATOR ?= verilator
TOP       ?= tbRvCore
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hw/*.sv dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, not the simulator exit code
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
